// File: design/aluPkg.sv
`default_nettype none

package aluPkg;

  // default operand width.
  localparam int dataWidth = 32;

  // ##########################################################################
  // request opcodes
  // ##########################################################################
  typedef enum logic [2:0] {
    opAdd,
    opSub,
    opXor,
    opSlt,
    opAnd,
    opOr,
    opNor,
    opNand
  } aluOp_e;

  // per-slice result select; codes 5 to 7 give 0.
  typedef enum logic [2:0] {
    selSum  = 3'd0,
    selXor  = 3'd1,
    selLess = 3'd2,
    selAnd  = 3'd3,
    selOr   = 3'd4
  } sliceSel_e;

  // response flags.
  typedef struct packed {
    logic carryOut;
    logic overflow;
    logic zero;
  } aluFlags_t;

endpackage

`default_nettype wire

// File: design/aluReqIf.sv
`timescale 1ns/10ps
`default_nettype none

interface aluReqIf #(
  parameter int width = aluPkg::dataWidth
);
  import aluPkg::*;

  logic             valid;
  aluOp_e           op;
  logic [width-1:0] a;
  logic [width-1:0] b;
  // removes the head entry when valid is high.
  logic             pop;

  modport queue (output valid, op, a, b, input pop);
  modport pipe (input valid, op, a, b, output pop);

endinterface

`default_nettype wire

// File: design/aluSlice.sv
`timescale 1ns/10ps
`default_nettype none

// ############################################################################
// one-bit slice
// ############################################################################
module aluSlice (
  input  aluPkg::sliceSel_e operation,
  input  logic              a,
  input  logic              b,
  input  logic              invertA,
  input  logic              invertB,
  input  logic              carryIn,
  input  logic              less,
  output logic              result,
  output logic              carryOut
);
  import aluPkg::*;

  logic opA;
  logic opB;
  logic sum;
  logic rawCarry;

  assign opA = invertA ? ~a : a;
  assign opB = invertB ? ~b : b;

  // full adder on the selected operands.
  assign sum      = opA ^ opB ^ carryIn;
  assign rawCarry = (opA & opB) | (carryIn & (opA ^ opB));

  // carry ripples on for add and for the compare.
  assign carryOut = rawCarry & ((operation == selSum) | (operation == selLess));

  always_comb begin
    case (operation)
      selSum:  result = sum;
      selXor:  result = a ^ b;
      selLess: result = less;
      selAnd:  result = opA & opB;
      selOr:   result = opA | opB;
      default: result = 1'b0;
    endcase
  end

endmodule

// ############################################################################
// most-significant slice, adds set and overflow
// ############################################################################
module aluSliceMsb (
  input  aluPkg::sliceSel_e operation,
  input  logic              a,
  input  logic              b,
  input  logic              invertA,
  input  logic              invertB,
  input  logic              carryIn,
  input  logic              less,
  output logic              result,
  output logic              carryOut,
  output logic              overflow,
  output logic              set
);
  import aluPkg::*;

  logic opA;
  logic opB;
  logic sum;
  logic rawCarry;
  logic isSum;

  assign opA = invertA ? ~a : a;
  assign opB = invertB ? ~b : b;

  assign sum      = opA ^ opB ^ carryIn;
  assign rawCarry = (opA & opB) | (carryIn & (opA ^ opB));
  assign isSum    = (operation == selSum);

  // flags only mean something for add and subtract.
  assign carryOut = rawCarry & isSum;
  assign overflow = (carryIn ^ rawCarry) & isSum;

  // sign of the wrapped difference, no overflow correction.
  assign set = sum;

  always_comb begin
    case (operation)
      selSum:  result = sum;
      selXor:  result = a ^ b;
      selLess: result = less;
      selAnd:  result = opA & opB;
      selOr:   result = opA | opB;
      default: result = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/aluCore.sv
`timescale 1ns/10ps
`default_nettype none

module aluCore #(
  parameter int width = aluPkg::dataWidth
) (
  input  aluPkg::sliceSel_e operation,
  input  logic              invertA,
  input  logic              invertB,
  input  logic              carryIn,
  input  logic [width-1:0]  a,
  input  logic [width-1:0]  b,
  output logic [width-1:0]  result,
  output aluPkg::aluFlags_t flags
);

  logic [width:0] carry;
  logic           set;
  logic           overflow;

  assign carry[0] = carryIn;

  // low slices; only bit 0 sees the compare result.
  for (genvar i = 0; i < width - 1; i++) begin : gSlice
    aluSlice uSlice (
      .operation(operation),
      .a        (a[i]),
      .b        (b[i]),
      .invertA  (invertA),
      .invertB  (invertB),
      .carryIn  (carry[i]),
      .less     ((i == 0) ? set : 1'b0),
      .result   (result[i]),
      .carryOut (carry[i+1])
    );
  end

  aluSliceMsb uMsb (
    .operation(operation),
    .a        (a[width-1]),
    .b        (b[width-1]),
    .invertA  (invertA),
    .invertB  (invertB),
    .carryIn  (carry[width-1]),
    .less     (1'b0),
    .result   (result[width-1]),
    .carryOut (carry[width]),
    .overflow (overflow),
    .set      (set)
  );

  assign flags = '{
    carryOut: carry[width],
    overflow: overflow,
    zero:     ~|result
  };

endmodule

`default_nettype wire

// File: design/reqQueue.sv
`timescale 1ns/10ps
`default_nettype none

module reqQueue #(
  parameter int width      = aluPkg::dataWidth,
  parameter int queueDepth = 4
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             wrValid,
  input  aluPkg::aluOp_e   wrOp,
  input  logic [width-1:0] wrA,
  input  logic [width-1:0] wrB,
  output logic             credit,
  aluReqIf.queue           deq
);
  import aluPkg::*;

  localparam int ptrWidth   = (queueDepth > 1) ? $clog2(queueDepth) : 1;
  localparam int countWidth = $clog2(queueDepth + 1);

  aluOp_e              opMem [queueDepth];
  logic [width-1:0]    aMem  [queueDepth];
  logic [width-1:0]    bMem  [queueDepth];
  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] rdPtr;
  logic [countWidth-1:0] count;
  logic                popNow;

  function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
    if (ptr == ptrWidth'(queueDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign popNow    = deq.pop & deq.valid;
  assign deq.valid = (count != '0);
  assign deq.op    = opMem[rdPtr];
  assign deq.a     = aMem[rdPtr];
  assign deq.b     = bMem[rdPtr];

  // storage.
  always_ff @(posedge clk) begin
    if (wrValid) begin
      opMem[wrPtr] <= wrOp;
      aMem[wrPtr]  <= wrA;
      bMem[wrPtr]  <= wrB;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr  <= '0;
      rdPtr  <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (wrValid) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (popNow) begin
        rdPtr <= nextPtr(rdPtr);
      end
      case ({wrValid, popNow})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // one credit back per popped entry.
      credit <= popNow;
    end
  end

  // upstream writes only while holding a credit.
  assert property (@(posedge clk) disable iff (rst)
    wrValid |-> (count != countWidth'(queueDepth)))
    else $error("reqQueue: write into a full queue");

endmodule

`default_nettype wire

// File: design/aluPipe.sv
`timescale 1ns/10ps
`default_nettype none

module aluPipe #(
  parameter int width       = aluPkg::dataWidth,
  parameter int respCredits = 2
) (
  input  logic              clk,
  input  logic              rst,
  aluReqIf.pipe             req,
  input  logic              respCredit,
  output aluPkg::sliceSel_e coreSel,
  output logic              coreInvA,
  output logic              coreInvB,
  output logic              coreCin,
  output logic [width-1:0]  coreA,
  output logic [width-1:0]  coreB,
  input  logic [width-1:0]  coreResult,
  input  aluPkg::aluFlags_t coreFlags,
  output logic              respValid,
  output logic [width-1:0]  respResult,
  output aluPkg::aluFlags_t respFlags
);
  import aluPkg::*;

  localparam int cntWidth = $clog2(respCredits + 1);
  localparam logic [cntWidth-1:0] maxCredits = cntWidth'(respCredits);

  logic [cntWidth-1:0] creditCnt;
  logic                pop;
  logic                decValid;
  sliceSel_e           nextSel;
  logic                nextInvA;
  logic                nextInvB;
  logic                nextCin;

  // a credit is reserved at pop, so no stage stalls.
  assign pop     = req.valid & (creditCnt != '0);
  assign req.pop = pop;

  // ##########################################################################
  // opcode decode
  // ##########################################################################
  always_comb begin
    nextSel  = selSum;
    nextInvA = 1'b0;
    nextInvB = 1'b0;
    nextCin  = 1'b0;
    case (req.op)
      opAdd: nextSel = selSum;
      opSub: begin
        nextSel  = selSum;
        nextInvB = 1'b1;
        nextCin  = 1'b1;
      end
      opXor: nextSel = selXor;
      opSlt: begin
        nextSel  = selLess;
        nextInvB = 1'b1;
        nextCin  = 1'b1;
      end
      opAnd: nextSel = selAnd;
      opOr:  nextSel = selOr;
      // de morgan on the inverted operands.
      opNor: begin
        nextSel  = selAnd;
        nextInvA = 1'b1;
        nextInvB = 1'b1;
      end
      opNand: begin
        nextSel  = selOr;
        nextInvA = 1'b1;
        nextInvB = 1'b1;
      end
      default: nextSel = selSum;
    endcase
  end

  // decode and result payload.
  always_ff @(posedge clk) begin
    if (pop) begin
      coreSel  <= nextSel;
      coreInvA <= nextInvA;
      coreInvB <= nextInvB;
      coreCin  <= nextCin;
      coreA    <= req.a;
      coreB    <= req.b;
    end
    if (decValid) begin
      respResult <= coreResult;
      respFlags  <= coreFlags;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      decValid  <= 1'b0;
      respValid <= 1'b0;
      creditCnt <= maxCredits;
    end else begin
      decValid  <= pop;
      respValid <= decValid;
      case ({pop, respCredit})
        2'b10:   creditCnt <= creditCnt - 1'b1;
        2'b01:   creditCnt <= creditCnt + 1'b1;
        default: creditCnt <= creditCnt;
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (rst) creditCnt <= maxCredits)
    else $error("aluPipe: response credits above the initial count");

  // downstream returns only what it was given.
  assert property (@(posedge clk) disable iff (rst)
    respCredit |-> (creditCnt != maxCredits))
    else $error("aluPipe: response credit with none outstanding");

endmodule

`default_nettype wire

// File: design/aluUnit.sv
`timescale 1ns/10ps
`default_nettype none

module aluUnit #(
  parameter int width       = aluPkg::dataWidth,
  parameter int queueDepth  = 4,
  parameter int respCredits = 2
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              reqValid,
  input  aluPkg::aluOp_e    reqOp,
  input  logic [width-1:0]  reqA,
  input  logic [width-1:0]  reqB,
  output logic              reqCredit,
  output logic              respValid,
  output logic [width-1:0]  respResult,
  output aluPkg::aluFlags_t respFlags,
  input  logic              respCredit
);
  import aluPkg::*;

  sliceSel_e        coreSel;
  logic             coreInvA;
  logic             coreInvB;
  logic             coreCin;
  logic [width-1:0] coreA;
  logic [width-1:0] coreB;
  logic [width-1:0] coreResult;
  aluFlags_t        coreFlags;

  aluReqIf #(.width(width)) reqBus ();

  reqQueue #(
    .width     (width),
    .queueDepth(queueDepth)
  ) uQueue (
    .clk    (clk),
    .rst    (rst),
    .wrValid(reqValid),
    .wrOp   (reqOp),
    .wrA    (reqA),
    .wrB    (reqB),
    .credit (reqCredit),
    .deq    (reqBus.queue)
  );

  aluPipe #(
    .width      (width),
    .respCredits(respCredits)
  ) uPipe (
    .clk       (clk),
    .rst       (rst),
    .req       (reqBus.pipe),
    .respCredit(respCredit),
    .coreSel   (coreSel),
    .coreInvA  (coreInvA),
    .coreInvB  (coreInvB),
    .coreCin   (coreCin),
    .coreA     (coreA),
    .coreB     (coreB),
    .coreResult(coreResult),
    .coreFlags (coreFlags),
    .respValid (respValid),
    .respResult(respResult),
    .respFlags (respFlags)
  );

  aluCore #(.width(width)) uCore (
    .operation(coreSel),
    .invertA  (coreInvA),
    .invertB  (coreInvB),
    .carryIn  (coreCin),
    .a        (coreA),
    .b        (coreB),
    .result   (coreResult),
    .flags    (coreFlags)
  );

endmodule

`default_nettype wire

// File: tests/aluUnitTb.sv
`timescale 1ns/10ps
`default_nettype none

module aluUnitTb;
  import aluPkg::*;

  localparam int width         = 32;
  localparam int queueDepth    = 4;
  localparam int respCredits   = 2;
  localparam int creditTimeout = 200;
  localparam int respTimeout   = 200;

  logic             clk;
  logic             rst;
  logic             reqValid;
  aluOp_e           reqOp;
  logic [width-1:0] reqA;
  logic [width-1:0] reqB;
  logic             reqCredit;
  logic             respValid;
  logic [width-1:0] respResult;
  aluFlags_t        respFlags;
  logic             respCredit;

  // vectors from the data file.
  logic [2:0]  vecOp[$];
  logic [31:0] vecA[$];
  logic [31:0] vecB[$];
  logic [31:0] vecRes[$];
  logic [2:0]  vecFlags[$];

  // scoreboard in request order, and cycles at which credits go back.
  int expIdx[$];
  int creditDue[$];

  int          cycle = 0;
  int          sentCount = 0;
  int          reqCreditsSeen = 0;
  int          respCount = 0;
  int          respCreditsSeen = 0;
  logic [31:0] lfsrState = 32'hfbad5872;

  aluUnit #(
    .width      (width),
    .queueDepth (queueDepth),
    .respCredits(respCredits)
  ) u_dut (
    .clk       (clk),
    .rst       (rst),
    .reqValid  (reqValid),
    .reqOp     (reqOp),
    .reqA      (reqA),
    .reqB      (reqB),
    .reqCredit (reqCredit),
    .respValid (respValid),
    .respResult(respResult),
    .respFlags (respFlags),
    .respCredit(respCredit)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ##########################################################################
  // helpers
  // ##########################################################################
  task automatic abortRun(input string what);
    $display("ERROR: %s", what);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "simulation stopped on the first mismatch");
    end
  endtask

  // taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  // three bits give a delay of 0 to 7 cycles.
  task automatic drawDelay(output int delay);
    int bitIdx;
    delay = 0;
    for (bitIdx = 0; bitIdx < 3; bitIdx++) begin
      lfsrState = lfsrNext(lfsrState);
      delay = (delay << 1) | int'(lfsrState[0]);
    end
  endtask

  task automatic readVectors();
    int          fd;
    int          fields;
    string       line;
    logic [31:0] op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] flags;
    fd = $fopen("tests/alu_testdata.txt", "r");
    if (fd == 0) begin
      abortRun("cannot open tests/alu_testdata.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 0 && line[0] != "#") begin
        fields = $sscanf(line, "%h %h %h %h %h", op, a, b, res, flags);
        if (fields == 5) begin
          vecOp.push_back(op[2:0]);
          vecA.push_back(a);
          vecB.push_back(b);
          vecRes.push_back(res);
          vecFlags.push_back(flags[2:0]);
        end else if (fields > 0) begin
          abortRun("malformed line in the data file");
        end
      end
    end
    $fclose(fd);
    if (vecOp.size() == 0) begin
      abortRun("the data file holds no vectors");
    end
  endtask

  // one request per falling edge while a queue credit is held.
  task automatic driveRequests();
    int idx;
    int waited;
    idx = 0;
    waited = 0;
    while (idx < vecOp.size()) begin
      @(negedge clk);
      if (sentCount - reqCreditsSeen < queueDepth) begin
        reqValid = 1'b1;
        reqOp    = aluOp_e'(vecOp[idx]);
        reqA     = vecA[idx];
        reqB     = vecB[idx];
        expIdx.push_back(idx);
        sentCount++;
        idx++;
        waited = 0;
      end else begin
        reqValid = 1'b0;
        waited++;
        if (waited > creditTimeout) begin
          abortRun("timed out waiting for a request credit");
        end
      end
    end
    @(negedge clk);
    reqValid = 1'b0;
  endtask

  // ##########################################################################
  // response monitor and credit return
  // ##########################################################################
  initial begin : monitor
    int     idx;
    int     delay;
    aluOp_e respOp;
    forever begin
      @(posedge clk);
      cycle++;
      if (reqCredit) begin
        reqCreditsSeen++;
      end
      if (respValid) begin
        if (expIdx.size() == 0) begin
          abortRun("respValid with no request outstanding");
        end
        idx = expIdx.pop_front();
        respOp = aluOp_e'(vecOp[idx]);
        checkValue($sformatf("vector %0d %s result", idx, respOp.name()),
                   vecRes[idx], respResult);
        checkValue($sformatf("vector %0d %s flags", idx, respOp.name()),
                   {29'b0, vecFlags[idx]}, {29'b0, respFlags});
        respCount++;
        if (respCount > respCreditsSeen + respCredits) begin
          abortRun("more responses than the response credits allow");
        end
        drawDelay(delay);
        creditDue.push_back(cycle + delay);
      end
      if (respCredit) begin
        respCreditsSeen++;
      end
    end
  end

  initial begin : creditReturn
    forever begin
      @(negedge clk);
      if (creditDue.size() > 0 && cycle >= creditDue[0]) begin
        respCredit = 1'b1;
        void'(creditDue.pop_front());
      end else begin
        respCredit = 1'b0;
      end
    end
  end

  // ##########################################################################
  // main sequence
  // ##########################################################################
  initial begin : mainSequence
    int waited;
    int lastCount;
    rst        = 1'b1;
    reqValid   = 1'b0;
    reqOp      = opAdd;
    reqA       = '0;
    reqB       = '0;
    respCredit = 1'b0;
    readVectors();

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // quiet outputs before any request.
    repeat (3) begin
      @(negedge clk);
      checkValue("respValid after reset", 32'd0, {31'b0, respValid});
      checkValue("reqCredit after reset", 32'd0, {31'b0, reqCredit});
    end

    driveRequests();

    waited = 0;
    lastCount = respCount;
    while (respCount < vecOp.size()) begin
      @(negedge clk);
      if (respCount != lastCount) begin
        lastCount = respCount;
        waited = 0;
      end else begin
        waited++;
      end
      if (waited > respTimeout) begin
        abortRun("timed out waiting for respValid");
      end
    end

    // all response credits back.
    waited = 0;
    while (respCreditsSeen < respCount) begin
      @(negedge clk);
      waited++;
      if (waited > respTimeout) begin
        abortRun("timed out waiting for the response credits to drain");
      end
    end

    // nothing extra may follow.
    repeat (8) begin
      @(negedge clk);
      checkValue("respValid when idle", 32'd0, {31'b0, respValid});
    end

    checkValue("request credits returned", sentCount, reqCreditsSeen);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
design/aluPkg.sv
design/aluReqIf.sv
design/aluSlice.sv
design/aluCore.sv
design/reqQueue.sv
design/aluPipe.sv
design/aluUnit.sv
tests/aluUnitTb.sv

// File: Makefile
OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
		--top-module aluUnitTb -f flist.f -Mdir $(OBJ_DIR) -o aluUnitTb
	./$(OBJ_DIR)/aluUnitTb

clean:
	rm -rf $(OBJ_DIR)

// File: tests/alu_testdata.txt
# columns, all hex: opcode operandA operandB result flags
# opcode 0 add 1 sub 2 xor 3 slt 4 and 5 or 6 nor 7 nand; flags are {carryOut, overflow, zero}
0 00000001 00000002 00000003 0
0 FFFFFFFF 00000001 00000000 5
0 7FFFFFFF 00000001 80000000 2
0 80000000 80000000 00000000 7
0 12345678 11111111 23456789 0
1 00000005 00000003 00000002 4
1 00000003 00000005 FFFFFFFE 0
1 12345678 12345678 00000000 5
1 80000000 00000001 7FFFFFFF 6
1 7FFFFFFF FFFFFFFF 80000000 2
1 00000000 00000000 00000000 5
2 F0F0F0F0 FF00FF00 0FF00FF0 0
2 A5A5A5A5 A5A5A5A5 00000000 1
3 00000003 00000005 00000001 0
3 00000005 00000003 00000000 1
3 80000000 00000001 00000000 1
3 FFFFFFFF 00000001 00000001 0
3 00000007 00000007 00000000 1
4 F0F0F0F0 FF00FF00 F000F000 0
4 0F0F0F0F F0F0F0F0 00000000 1
5 F0F0F0F0 0F0F0F0F FFFFFFFF 0
6 F0F0F0F0 0F0F0F0F 00000000 1
6 00000000 00000000 FFFFFFFF 0
7 FFFFFFFF FFFFFFFF 00000000 1
7 F0F0F0F0 FF00FF00 0FFF0FFF 0
